// File: design/ppu_pkg.sv
// PPU front end definitions

package ppu_pkg;

  // ====================
  // Bus widths
  // ====================

  // N64 colour channel in, output channel after expansion
  localparam int COLOR_W_I = 7;
  localparam int COLOR_W_O = 8;

  // Sync view of the VD bus, active low bits
  typedef struct packed {
    logic [2:0] pad;
    logic       vsync_n;
    logic       clamp_n;
    logic       hsync_n;
    logic       csync_n;
  } vd_sync_t;

  // One VD bus word, sync in the sync phase and colour otherwise
  typedef union packed {
    logic [COLOR_W_I-1:0] color;
    vd_sync_t             sync;
  } vd_word_u;

  // ====================
  // Configuration word
  // ====================

  localparam int CFG_W           = 8;
  localparam int CFG_TARGET_LSB  = 0;
  localparam int CFG_TARGET_W    = 3;
  localparam int CFG_VGA_BIT     = 3;
  localparam int CFG_FORCE60_BIT = 4;
  localparam int CFG_FORCE50_BIT = 5;
  localparam int CFG_LLM_BIT     = 6;
  // Set means 16-bit colour mode
  localparam int CFG_N16BIT_BIT  = 7;

  // Target codes, 0 and 7 depend on the 50/60 Hz decision
  localparam logic [2:0] TARGET_480P    = 3'd0;
  localparam logic [2:0] TARGET_720P    = 3'd1;
  localparam logic [2:0] TARGET_960P    = 3'd2;
  localparam logic [2:0] TARGET_1080P   = 3'd3;
  localparam logic [2:0] TARGET_1200P   = 3'd4;
  localparam logic [2:0] TARGET_1440P   = 3'd5;
  localparam logic [2:0] TARGET_1440WP  = 3'd6;
  localparam logic [2:0] TARGET_LOWRES  = 3'd7;

  // ====================
  // Video mode and state
  // ====================

  // Mode code is {50 Hz, target, VGA}
  localparam int VMODE_W          = 5;
  localparam int VMODE_50HZ_BIT   = 4;
  localparam int VMODE_TARGET_LSB = 1;
  localparam int VMODE_VGA_BIT    = 0;

  localparam int PPU_STATE_W = 8;

endpackage

// File: design/n64_vdemux.sv
// N64 video bus demultiplexer

module n64_vdemux
  import ppu_pkg::*;
(
  input  logic                   N64_CLK_i,
  input  logic                   reset_i,
  input  logic                   nvdsync_i,
  input  logic                   n16bit_i,
  input  logic [COLOR_W_I-1:0]   vd_i,
  output vd_word_u               sync_o,
  output logic                   pix_valid_o,
  output logic                   vsync_o,
  output logic                   hsync_o,
  output logic                   csync_o,
  output logic [3*COLOR_W_O-1:0] vd_o
);

  vd_word_u               vd_w;
  vd_word_u               sync_q;
  logic [1:0]             phase_q;
  logic                   pix_valid_q;
  logic [COLOR_W_I-1:0]   red_q;
  logic [COLOR_W_I-1:0]   green_q;
  logic [3*COLOR_W_O-1:0] vd_q;

  // Optional 16-bit masking, then MSB replicated below the LSB
  function automatic logic [COLOR_W_O-1:0] expand_color(
    input logic [COLOR_W_I-1:0] c,
    input logic                 mask16
  );
    logic [COLOR_W_I-1:0] m;
    m = c;
    if (mask16) begin
      m[1:0] = 2'b00;
    end
    return {m, m[COLOR_W_I-1]};
  endfunction

  assign vd_w = vd_i;

  // Phase 0 waits for nVDSYNC, phases 1 to 3 are R, G, B
  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      phase_q     <= 2'd0;
      sync_q      <= '1;
      pix_valid_q <= 1'b0;
    end else begin
      pix_valid_q <= 1'b0;
      if (!nvdsync_i) begin
        phase_q <= 2'd1;
        sync_q  <= vd_w;
      end else if (phase_q != 2'd0) begin
        phase_q <= phase_q + 2'd1;
        if (phase_q == 2'd3) begin
          pix_valid_q <= 1'b1;
        end
      end
    end
  end

  // Colour samples and the assembled pixel
  always_ff @(posedge N64_CLK_i) begin
    if (nvdsync_i) begin
      case (phase_q)
        2'd1: red_q   <= vd_w.color;
        2'd2: green_q <= vd_w.color;
        2'd3: vd_q    <= {expand_color(red_q, n16bit_i),
                          expand_color(green_q, n16bit_i),
                          expand_color(vd_w.color, n16bit_i)};
        default: ;
      endcase
    end
  end

  assign sync_o      = sync_q;
  assign vsync_o     = ~sync_q.sync.vsync_n;
  assign hsync_o     = ~sync_q.sync.hsync_n;
  assign csync_o     = ~sync_q.sync.csync_n;
  assign pix_valid_o = pix_valid_q;
  assign vd_o        = vd_q;

  // One pixel per four-phase group
  a_single_valid: assert property (@(posedge N64_CLK_i) disable iff (reset_i)
    pix_valid_o |=> !pix_valid_o)
    else $error("pix_valid_o high on two consecutive cycles");

endmodule

// File: design/n64_vinfo_detect.sv
// PAL and interlace detection

module n64_vinfo_detect
  import ppu_pkg::*;
#(
  parameter int PAL_LINES_MIN = 288
) (
  input  logic     N64_CLK_i,
  input  logic     reset_i,
  input  vd_word_u sync_i,
  input  logic     sync_strobe_i,
  output logic     palmode_o,
  output logic     n64_480i_o
);

  localparam int LINE_W = 10;

  logic              strobe_q;
  logic              hs_prev_q;
  logic              vs_prev_q;
  logic              hs_fall;
  logic              vs_fall;
  logic [LINE_W-1:0] line_cnt_q;
  logic [LINE_W-1:0] last_cnt_q;
  // First vsync seen, and one complete field counted
  logic              field_start_q;
  logic              last_valid_q;
  logic              palmode_q;
  logic              n64_480i_q;

  // The demux registers the sync word one cycle after the strobe
  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= sync_strobe_i;
    end
  end

  assign hs_fall = hs_prev_q & ~sync_i.sync.hsync_n;
  assign vs_fall = vs_prev_q & ~sync_i.sync.vsync_n;

  // ====================
  // Line and field count
  // ====================

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      hs_prev_q     <= 1'b1;
      vs_prev_q     <= 1'b1;
      line_cnt_q    <= '0;
      last_cnt_q    <= '0;
      field_start_q <= 1'b0;
      last_valid_q  <= 1'b0;
      palmode_q     <= 1'b0;
      n64_480i_q    <= 1'b0;
    end else if (strobe_q) begin
      hs_prev_q <= sync_i.sync.hsync_n;
      vs_prev_q <= sync_i.sync.vsync_n;
      if (vs_fall) begin
        // Field done, decide only on a complete field
        if (field_start_q) begin
          palmode_q <= (line_cnt_q >= LINE_W'(PAL_LINES_MIN));
        end
        if (last_valid_q) begin
          n64_480i_q <= (line_cnt_q != last_cnt_q);
        end
        last_cnt_q    <= line_cnt_q;
        last_valid_q  <= field_start_q;
        field_start_q <= 1'b1;
        // First line of the new field starts in this group
        line_cnt_q    <= hs_fall ? LINE_W'(1) : '0;
      end else if (hs_fall && line_cnt_q != '1) begin
        line_cnt_q <= line_cnt_q + 1'b1;
      end
    end
  end

  assign palmode_o  = palmode_q;
  assign n64_480i_o = n64_480i_q;

  // Vsync must come long before the count runs out
  a_no_saturate: assert property (@(posedge N64_CLK_i) disable iff (reset_i)
    line_cnt_q != '1)
    else $error("line counter saturated, vsync missing");

endmodule

// File: design/vmode_select.sv
// Output video mode selection

module vmode_select
  import ppu_pkg::*;
(
  input  logic               N64_CLK_i,
  input  logic               reset_i,
  input  logic               palmode_i,
  input  logic [CFG_W-1:0]   cfg_i,
  output logic [VMODE_W-1:0] vmode_o
);

  logic [CFG_TARGET_W-1:0] target;
  logic                    force_ok;
  logic                    use50;
  logic                    vga;
  logic [VMODE_W-1:0]      vmode_q;

  assign target = cfg_i[CFG_TARGET_LSB +: CFG_TARGET_W];

  // No forcing in low latency mode or for the low resolution target
  assign force_ok = ~cfg_i[CFG_LLM_BIT] & (target != TARGET_LOWRES);

  always_comb begin
    if (cfg_i[CFG_FORCE60_BIT] && force_ok) begin
      use50 = 1'b0;
    end else if (cfg_i[CFG_FORCE50_BIT] && force_ok) begin
      use50 = 1'b1;
    end else begin
      use50 = palmode_i;
    end
  end

  // VGA timing only replaces 480p60
  assign vga = ~use50 & (target == TARGET_480P) & cfg_i[CFG_VGA_BIT];

  // ====================
  // Mode register
  // ====================

  // 1440WP and all other targets keep their code, only the rate bit differs
  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      vmode_q <= '0;
    end else begin
      vmode_q[VMODE_50HZ_BIT]                       <= use50;
      vmode_q[VMODE_TARGET_LSB +: CFG_TARGET_W]     <= target;
      vmode_q[VMODE_VGA_BIT]                        <= vga;
    end
  end

  assign vmode_o = vmode_q;

  // Low latency mode tracks the detected input rate
  a_llm_follows_pal: assert property (@(posedge N64_CLK_i) disable iff (reset_i)
    cfg_i[CFG_LLM_BIT] |=> vmode_o[VMODE_50HZ_BIT] == $past(palmode_i))
    else $error("llm set but 50 Hz flag differs from palmode");

endmodule

// File: design/n64_ppu_top.sv
// N64 PPU front end top

module n64_ppu_top
  import ppu_pkg::*;
#(
  parameter int PAL_LINES_MIN = 288
) (
  input  logic                   N64_CLK_i,
  input  logic                   reset_i,
  input  logic                   nvdsync_i,
  input  logic [COLOR_W_I-1:0]   vd_i,
  input  logic [CFG_W-1:0]       cfg_i,
  output logic                   pix_valid_o,
  output logic                   vsync_o,
  output logic                   hsync_o,
  output logic                   csync_o,
  output logic [3*COLOR_W_O-1:0] vd_o,
  output logic [PPU_STATE_W-1:0] ppu_state_o
);

  vd_word_u           sync_w;
  logic               palmode_w;
  logic               n64_480i_w;
  logic [VMODE_W-1:0] vmode_w;

  // ====================
  // Video data demux
  // ====================

  n64_vdemux u_vdemux (
    .N64_CLK_i   (N64_CLK_i),
    .reset_i     (reset_i),
    .nvdsync_i   (nvdsync_i),
    .n16bit_i    (cfg_i[CFG_N16BIT_BIT]),
    .vd_i        (vd_i),
    .sync_o      (sync_w),
    .pix_valid_o (pix_valid_o),
    .vsync_o     (vsync_o),
    .hsync_o     (hsync_o),
    .csync_o     (csync_o),
    .vd_o        (vd_o)
  );

  // Input video info
  n64_vinfo_detect #(
    .PAL_LINES_MIN (PAL_LINES_MIN)
  ) u_vinfo (
    .N64_CLK_i     (N64_CLK_i),
    .reset_i       (reset_i),
    .sync_i        (sync_w),
    .sync_strobe_i (~nvdsync_i),
    .palmode_o     (palmode_w),
    .n64_480i_o    (n64_480i_w)
  );

  vmode_select u_vmode (
    .N64_CLK_i (N64_CLK_i),
    .reset_i   (reset_i),
    .palmode_i (palmode_w),
    .cfg_i     (cfg_i),
    .vmode_o   (vmode_w)
  );

  // State word is {vmode, palmode, 480i, 16-bit mode}
  assign ppu_state_o = {vmode_w, palmode_w, n64_480i_w, cfg_i[CFG_N16BIT_BIT]};

endmodule

// File: tb/tb_ppu_top.sv
// PPU front end testbench

module tb_ppu_top
  import ppu_pkg::*;
();

  // Four fields of 320 lines, 2 pixels of 4 cycles, with a margin of 6
  localparam int WATCHDOG_T = 4 * 320 * 2 * 4 * 8 * 6;

  logic        n64_clk = 1'b0;
  logic        reset;
  logic        nvdsync;
  logic [6:0]  vd;
  logic [7:0]  cfg;
  logic        pix_valid;
  logic        vsync;
  logic        hsync;
  logic        csync;
  logic [23:0] vd_out;
  logic [7:0]  ppu_state;
  logic [31:0] lfsr;
  // {vsync, hsync, csync, rgb} for each group sent
  logic [26:0] exp_q[$];

  n64_ppu_top #(
    .PAL_LINES_MIN (288)
  ) DUT (
    .N64_CLK_i   (n64_clk),
    .reset_i     (reset),
    .nvdsync_i   (nvdsync),
    .vd_i        (vd),
    .cfg_i       (cfg),
    .pix_valid_o (pix_valid),
    .vsync_o     (vsync),
    .hsync_o     (hsync),
    .csync_o     (csync),
    .vd_o        (vd_out),
    .ppu_state_o (ppu_state)
  );

  always #4 n64_clk = ~n64_clk;

  // ====================
  // Helpers
  // ====================

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s, got %0h expected %0h",
                               $time, msg, got, exp));
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output logic [6:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[5:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // 16-bit mode clears 2 LSBs, then the MSB fills the new low bit
  function automatic logic [7:0] expected_color(input logic [6:0] c, input logic mode16);
    logic [6:0] m;
    m = mode16 ? (c & 7'b1111100) : c;
    return {m, m[6]};
  endfunction

  function automatic logic [6:0] sync_word(input logic vs_n, input logic hs_n);
    return {3'b000, vs_n, 1'b1, hs_n, vs_n & hs_n};
  endfunction

  task automatic set_cfg(input logic [7:0] v);
    @(posedge n64_clk);
    cfg <= v;
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge n64_clk);
    @(negedge n64_clk);
  endtask

  task automatic send_pixel(input logic [6:0] s, input logic [6:0] r,
                            input logic [6:0] g, input logic [6:0] b);
    logic mode16;
    @(posedge n64_clk);
    // Mode as the DUT sees it for this group
    mode16 = cfg[CFG_N16BIT_BIT];
    exp_q.push_back({~s[3], ~s[1], ~s[0], expected_color(r, mode16),
                     expected_color(g, mode16), expected_color(b, mode16)});
    nvdsync <= 1'b0;
    vd      <= s;
    @(posedge n64_clk);
    nvdsync <= 1'b1;
    vd      <= r;
    @(posedge n64_clk);
    vd <= g;
    @(posedge n64_clk);
    vd <= b;
  endtask

  // Hsync low on the first group of a line, vsync low on line 0
  task automatic send_field(input int lines);
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < 2; p++) begin
        send_pixel(sync_word(l != 0, p != 0), '0, '0, '0);
      end
    end
  endtask

  // A lone vsync group ends the field so the detector decides on it
  task automatic close_field();
    send_pixel(sync_word(1'b0, 1'b0), '0, '0, '0);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 16) begin
      @(posedge n64_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_failure("pixel output missing, no valid pulse for a sent group");
    end
  endtask

  // Compares each valid pulse with the oldest group sent
  always @(negedge n64_clk) begin
    if (!reset && pix_valid) begin
      if (exp_q.size() == 0) begin
        report_failure("pixel valid pulse with no pixel sent");
      end else begin
        check(vd_out, exp_q[0][23:0], "pixel colour");
        check({vsync, hsync, csync}, exp_q[0][26:24], "sync outputs");
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_T);
    report_failure("timeout, the tests did not finish in the allowed time");
  end

  // ====================
  // Tests
  // ====================

  task automatic test_reset_state();
    @(negedge n64_clk);
    check(pix_valid, 1'b0, "pixel valid after reset");
    check({vsync, hsync, csync}, 3'b000, "sync outputs after reset");
    check(ppu_state[7:1], 7'd0, "state word after reset");
  endtask

  task automatic test_pixels(input logic mode16);
    logic [6:0] s;
    logic [6:0] r;
    logic [6:0] g;
    logic [6:0] b;
    set_cfg({mode16, 7'b0});
    repeat (40) begin
      random_bits(4, s);
      random_bits(7, r);
      random_bits(7, g);
      random_bits(7, b);
      send_pixel(s, r, g, b);
    end
    wait_drained();
    check(ppu_state[0], mode16, "16-bit flag in state word");
  endtask

  task automatic test_vinfo();
    set_cfg(8'h00);
    repeat (3) send_field(262);
    close_field();
    settle(4);
    check(ppu_state[2:1], 2'b00, "NTSC progressive detection");
    send_field(312);
    send_field(313);
    send_field(312);
    send_field(313);
    close_field();
    settle(4);
    check(ppu_state[2:1], 2'b11, "PAL interlaced detection");
  endtask

  task automatic check_mode(input logic [7:0] c, input logic pal,
                            input logic [4:0] mode, input string msg);
    set_cfg(c);
    settle(3);
    check(ppu_state[7:2], {mode, pal}, msg);
    check(ppu_state[0], c[CFG_N16BIT_BIT], "16-bit flag in state word");
  endtask

  task automatic test_mode();
    // PAL input left by the detection test
    check_mode(8'h11, 1'b1, 5'b00010, "force60 on PAL input");
    check_mode(8'h51, 1'b1, 5'b10010, "force60 with llm");
    check_mode(8'h26, 1'b1, 5'b11100, "force50 with 1440WP");
    check_mode(8'h08, 1'b1, 5'b10000, "VGA bit at 50 Hz");
    set_cfg(8'h00);
    send_field(262);
    close_field();
    settle(4);
    check(ppu_state[2], 1'b0, "NTSC input for mode tests");
    check_mode(8'h27, 1'b0, 5'b01110, "LOWRES ignores force50");
    check_mode(8'h08, 1'b0, 5'b00001, "VGA bit at 60 Hz");
    check_mode(8'h09, 1'b0, 5'b00010, "VGA bit with 720p");
    check_mode(8'h28, 1'b0, 5'b10000, "force50 drops VGA");
  endtask

  initial begin
    reset   = 1'b1;
    nvdsync = 1'b1;
    vd      = '0;
    cfg     = '0;
    lfsr    = 32'h9f31;
    repeat (2) @(posedge n64_clk);
    reset <= 1'b0;
    test_reset_state();
    test_pixels(1'b0);
    test_pixels(1'b1);
    test_vinfo();
    test_mode();
    $display("all tests passed");
    $finish;
  end

endmodule

// File: list.f
design/ppu_pkg.sv
design/n64_vdemux.sv
design/n64_vinfo_detect.sv
design/vmode_select.sv
design/n64_ppu_top.sv
tb/tb_ppu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the PPU front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu_top -f list.f -o sim_ppu
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/sim_ppu > sim.log 2>&1
status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "PASS"
exit 0
